// File: design/fpFormatPkg.sv
/*
 * floating-point format description
 */

`default_nettype none

package fpFormatPkg;

    ////////////////////
    // word widths
    ////////////////////

    // widest floating-point register word
    parameter int FLEN = 64;

    // integer register width for conversion results
    parameter int XLEN = 64;

    ////////////////////
    // double fields
    ////////////////////

    // exponent bits
    parameter int NE = 11;
    // fraction bits, hidden bit excluded
    parameter int NF = 52;

    ////////////////////
    // single fields
    ////////////////////

    // exponent bits
    parameter int NE1 = 8;
    // fraction bits
    parameter int NF1 = 23;
    // packed single word, sits in the low half of a FLEN word
    parameter int LEN1 = 32;

    // one floating-point register word
    typedef logic [FLEN-1:0] fpWord_t;

    // output format select
    // single results are NaN-boxed up to FLEN
    typedef enum logic {
        fmtSingle = 1'b0,
        fmtDouble = 1'b1
    } fmt_t;

endpackage

`default_nettype wire

// File: design/specialCasePkg.sv
/*
 * special case operation and result types
 */

`default_nettype none

package specialCasePkg;

    import fpFormatPkg::*;

    ////////////////////
    // encodings
    ////////////////////

    // riscv frm field
    typedef enum logic [2:0] {
        rne = 3'b000,
        rtz = 3'b001,
        rdn = 3'b010,
        rup = 3'b011,
        rmm = 3'b100
    } frm_t;

    // which unit produced the rounded value
    typedef enum logic [1:0] {
        opArith = 2'b00,
        opDiv   = 2'b01,
        opCvt   = 2'b10
    } opKind_t;

    // chosen floating-point result
    typedef enum logic [2:0] {
        clsXNaN     = 3'd0,
        clsYNaN     = 3'd1,
        clsInvalid  = 3'd2,
        clsOverflow = 3'd3,
        clsKill     = 3'd4,
        clsNorm     = 3'd5
    } fpClass_t;

    // chosen integer conversion result
    typedef enum logic [1:0] {
        intOverflow  = 2'd0,
        intUnderflow = 2'd1,
        intNormal    = 2'd2
    } intClass_t;

    ////////////////////
    // pipeline structs
    ////////////////////

    // everything upstream hands to the selector
    typedef struct packed {
        // operand sign, significands and nan flags
        logic               xs;
        logic [NF:0]        xm;
        logic [NF:0]        ym;
        logic               xNaN;
        logic               yNaN;
        frm_t               frm;
        fmt_t               outFmt;
        // operand classification
        logic               infIn;
        logic               nanIn;
        logic               xInf;
        logic               yInf;
        logic               xZero;
        logic               intZero;
        // operation kind
        logic               intToFp;
        logic               int64;
        logic               isSigned;
        opKind_t            op;
        logic               plus1;
        logic               divByZero;
        // conversion exponent, top bit flags underflow
        logic [NE:0]        cvtCe;
        // rounded result sign and flags
        logic               ws;
        logic               intInvalid;
        logic               invalid;
        logic               overflow;
        logic               cvtResUf;
        // rounded exponent and fraction
        logic [NE-1:0]      re;
        logic [NE+1:0]      fullRe;
        logic [NF-1:0]      rf;
        // negated conversion result
        logic [XLEN+1:0]    cvtNegRes;
    } specialCaseIn_t;

    // classifier register, feeds both output stages
    typedef struct packed {
        fpClass_t           fpClass;
        logic               ofResMax;
        logic               ufLsb;
        logic               ws;
        fmt_t               outFmt;
        logic [NF-2:0]      xPayload;
        logic [NF-2:0]      yPayload;
        logic [NE-1:0]      re;
        logic [NF-1:0]      rf;
        intClass_t          intClass;
        logic               intNeg;
        logic               isSigned;
        logic               int64;
        logic               plus1;
        logic [XLEN-1:0]    cvtNegRes;
    } stageOne_t;

endpackage

`default_nettype wire

// File: design/resultClassifier.sv
/*
 * result class decision stage
 */

`timescale 1ns/100ps
`default_nettype none

module resultClassifier
    import fpFormatPkg::*;
    import specialCasePkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  specialCaseIn_t  opIn,
    output logic            stageValid,
    output stageOne_t       stage
);

    // op kind decodes
    logic       cvtOp;
    logic       divOp;
    // class selects
    logic       selOfRes;
    logic       killRes;
    logic       ofResMax;
    logic       ufLsb;
    fpClass_t   fpClass;
    intClass_t  intClass;
    stageOne_t  stageNext;

    assign cvtOp = (opIn.op == opCvt);
    assign divOp = (opIn.op == opDiv);

    ////////////////////
    // fp class
    ////////////////////

    // inf input overflows unless it is inf divisor, x/inf is a zero
    assign selOfRes = opIn.overflow | opIn.divByZero | (opIn.infIn & ~(opIn.yInf & divOp));

    // conversions kill on underflow or a zero on the side actually used
    // other ops kill on exponent underflow, 0/y or x/inf
    always_comb begin
        if (cvtOp) begin
            killRes = opIn.cvtResUf | (opIn.xZero & ~opIn.intToFp)
                    | (opIn.intZero & opIn.intToFp);
        end else begin
            killRes = opIn.fullRe[NE+1]
                    | (((opIn.yInf & ~opIn.xInf) | opIn.xZero) & divOp);
        end
    end

    // int-to-fp has no fp x operand, any conversion has no y
    always_comb begin
        if (opIn.xNaN & ~(opIn.intToFp & cvtOp)) begin
            fpClass = clsXNaN;
        end else if (opIn.yNaN & ~cvtOp) begin
            fpClass = clsYNaN;
        end else if (opIn.invalid) begin
            fpClass = clsInvalid;
        end else if (selOfRes) begin
            fpClass = clsOverflow;
        end else if (killRes) begin
            fpClass = clsKill;
        end else begin
            fpClass = clsNorm;
        end
    end

    // overflow saturates to max finite when rounding toward zero
    // inf input or divide by zero always gives inf
    assign ofResMax = (~opIn.infIn | (opIn.intToFp & cvtOp)) & ~opIn.divByZero
                    & ((opIn.frm == rtz) | ((opIn.frm == rdn) & ~opIn.ws)
                    | ((opIn.frm == rup) & opIn.ws));

    // x/inf is an exact zero, no rounding lsb
    assign ufLsb = opIn.plus1 & opIn.frm[1] & ~(divOp & opIn.yInf);

    ////////////////////
    // int class
    ////////////////////

    always_comb begin
        if (opIn.intInvalid) begin
            intClass = intOverflow;
        end else if (opIn.cvtCe[NE]) begin
            intClass = intUnderflow;
        end else begin
            intClass = intNormal;
        end
    end

    // stage register contents
    always_comb begin
        stageNext.fpClass   = fpClass;
        stageNext.ofResMax  = ofResMax;
        stageNext.ufLsb     = ufLsb;
        stageNext.ws        = opIn.ws;
        stageNext.outFmt    = opIn.outFmt;
        // quiet bit is forced later, keep the rest
        stageNext.xPayload  = opIn.xm[NF-2:0];
        stageNext.yPayload  = opIn.ym[NF-2:0];
        stageNext.re        = opIn.re;
        stageNext.rf        = opIn.rf;
        stageNext.intClass  = intClass;
        // nan converts as positive
        stageNext.intNeg    = opIn.xs & ~opIn.nanIn;
        stageNext.isSigned  = opIn.isSigned;
        stageNext.int64     = opIn.int64;
        stageNext.plus1     = opIn.plus1;
        stageNext.cvtNegRes = opIn.cvtNegRes[XLEN-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= inValid;
        end
    end

    // data holds when idle
    always_ff @(posedge clk) begin
        if (inValid) begin
            stage <= stageNext;
        end
    end

endmodule

`default_nettype wire

// File: design/fpResultFormatter.sv
/*
 * floating-point result builder
 */

`timescale 1ns/100ps
`default_nettype none

module fpResultFormatter
    import fpFormatPkg::*;
    import specialCasePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stageValid,
    input  stageOne_t   stage,
    output logic        outValid,
    output fpWord_t     fpRes
);

    // payload below the quiet bit, zero for the canonical nan
    logic [NF-2:0]      nanPayload;
    logic [FLEN-1:0]    dblWord;
    logic [LEN1-1:0]    sglWord;
    fpWord_t            fpNext;

    always_comb begin
        case (stage.fpClass)
            clsXNaN: nanPayload = stage.xPayload;
            clsYNaN: nanPayload = stage.yPayload;
            default: nanPayload = '0;
        endcase
    end

    ////////////////////
    // double word
    ////////////////////

    always_comb begin
        case (stage.fpClass)
            clsXNaN, clsYNaN, clsInvalid: begin
                // quiet nan, sign always clear
                dblWord = {1'b0, {NE{1'b1}}, 1'b1, nanPayload};
            end
            clsOverflow: begin
                if (stage.ofResMax) begin
                    dblWord = {stage.ws, {NE-1{1'b1}}, 1'b0, {NF{1'b1}}};
                end else begin
                    dblWord = {stage.ws, {NE{1'b1}}, {NF{1'b0}}};
                end
            end
            // signed zero, or smallest denormal when rounded up
            clsKill: dblWord = {stage.ws, {FLEN-2{1'b0}}, stage.ufLsb};
            default: dblWord = {stage.ws, stage.re, stage.rf};
        endcase
    end

    ////////////////////
    // single word
    ////////////////////

    // single keeps the top of the fraction and low exponent bits
    always_comb begin
        case (stage.fpClass)
            clsXNaN, clsYNaN, clsInvalid: begin
                sglWord = {1'b0, {NE1{1'b1}}, 1'b1, nanPayload[NF-2 -: NF1-1]};
            end
            clsOverflow: begin
                if (stage.ofResMax) begin
                    sglWord = {stage.ws, {NE1-1{1'b1}}, 1'b0, {NF1{1'b1}}};
                end else begin
                    sglWord = {stage.ws, {NE1{1'b1}}, {NF1{1'b0}}};
                end
            end
            clsKill: sglWord = {stage.ws, {LEN1-2{1'b0}}, stage.ufLsb};
            default: sglWord = {stage.ws, stage.re[NE1-1:0], stage.rf[NF-1 -: NF1]};
        endcase
    end

    // nan-box single into the upper half
    assign fpNext = (stage.outFmt == fmtDouble) ? dblWord
                                                : {{FLEN-LEN1{1'b1}}, sglWord};

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= stageValid;
        end
    end

    always_ff @(posedge clk) begin
        if (stageValid) begin
            fpRes <= fpNext;
        end
    end

endmodule

`default_nettype wire

// File: design/intResultSelector.sv
/*
 * integer conversion result select
 */

`timescale 1ns/100ps
`default_nettype none

module intResultSelector
    import fpFormatPkg::*;
    import specialCasePkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            stageValid,
    input  stageOne_t       stage,
    output logic [XLEN-1:0] intRes
);

    logic               loadValid;
    logic [XLEN-1:0]    ofIntRes;
    logic [XLEN-1:0]    intNext;

    ////////////////////
    // overflow table
    ////////////////////

    // out of range, inf and nan inputs saturate
    // nan arrives with intNeg already clear
    always_comb begin
        if (stage.isSigned) begin
            if (stage.intNeg) begin
                if (stage.int64) begin
                    ofIntRes = {1'b1, {XLEN-1{1'b0}}};
                end else begin
                    // -2^31 sign-extended
                    ofIntRes = {{XLEN-31{1'b1}}, {31{1'b0}}};
                end
            end else begin
                if (stage.int64) begin
                    ofIntRes = {1'b0, {XLEN-1{1'b1}}};
                end else begin
                    ofIntRes = {{XLEN-31{1'b0}}, {31{1'b1}}};
                end
            end
        end else begin
            // unsigned: negatives clamp to 0, positives to all ones
            ofIntRes = stage.intNeg ? {XLEN{1'b0}} : {XLEN{1'b1}};
        end
    end

    ////////////////////
    // final select
    ////////////////////

    always_comb begin
        case (stage.intClass)
            intOverflow: intNext = ofIntRes;
            intUnderflow: begin
                // tiny negative rounded away from zero is -1
                if (stage.intNeg & stage.isSigned & stage.plus1) begin
                    intNext = {XLEN{1'b1}};
                end else begin
                    intNext = {{XLEN-1{1'b0}}, stage.plus1};
                end
            end
            default: begin
                // 32-bit results sign-extend, unsigned too
                if (stage.int64) begin
                    intNext = stage.cvtNegRes;
                end else begin
                    intNext = {{XLEN-32{stage.cvtNegRes[31]}}, stage.cvtNegRes[31:0]};
                end
            end
        endcase
    end

    // reset blocks a stray load from a stale stage word
    assign loadValid = stageValid & ~rst;

    always_ff @(posedge clk) begin
        if (loadValid) begin
            intRes <= intNext;
        end
    end

endmodule

`default_nettype wire

// File: design/specialCaseTop.sv
/*
 * special case selector top
 */

`timescale 1ns/100ps
`default_nettype none

module specialCaseTop
    import fpFormatPkg::*;
    import specialCasePkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  specialCaseIn_t  opIn,
    output logic            outValid,
    output fpWord_t         fpRes,
    output logic [XLEN-1:0] intRes
);

    // stage one to both output stages
    logic       stageValid;
    stageOne_t  stage;

    resultClassifier i_resultClassifier (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .opIn       (opIn),
        .stageValid (stageValid),
        .stage      (stage)
    );

    // fp path also owns the output valid
    fpResultFormatter i_fpResultFormatter (
        .clk        (clk),
        .rst        (rst),
        .stageValid (stageValid),
        .stage      (stage),
        .outValid   (outValid),
        .fpRes      (fpRes)
    );

    intResultSelector i_intResultSelector (
        .clk        (clk),
        .rst        (rst),
        .stageValid (stageValid),
        .stage      (stage),
        .intRes     (intRes)
    );

endmodule

`default_nettype wire

// File: dv/specialCaseTasks.svh
/*
 * selector stimulus and reference
 */

`ifndef SPECIALCASETASKS_SVH
`define SPECIALCASETASKS_SVH

////////////////////
// run control
////////////////////

task automatic stopWithFailure();
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
endtask

task automatic checkFp(input string name, input fpWord_t expected, input fpWord_t actual);
    if (actual !== expected) begin
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        stopWithFailure();
    end
endtask

task automatic checkInt(input string name, input logic [XLEN-1:0] expected,
                        input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        stopWithFailure();
    end
endtask

// one op per rising edge
task automatic issueOp(input specialCaseIn_t o);
    @(posedge clk);
    inValid <= 1'b1;
    opIn <= o;
endtask

// stop issuing and wait until every result came back
task automatic finishTest();
    @(posedge clk);
    inValid <= 1'b0;
    while (dueQ.size() != 0) begin
        @(posedge clk);
    end
endtask

////////////////////
// stimulus
////////////////////

function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
endfunction

// all flags clear with random operands under rne
function automatic specialCaseIn_t quietOp(input logic dbl);
    specialCaseIn_t o;
    logic [63:0]    r;
    o = '0;
    o.outFmt = dbl ? fmtDouble : fmtSingle;
    r = rand64();
    o.xm = r[NF:0];
    o.xs = r[63];
    o.ws = r[62];
    r = rand64();
    o.ym = r[NF:0];
    o.isSigned = r[63];
    o.int64 = r[62];
    r = rand64();
    o.re = r[NE-1:0];
    // exponent in range without underflow
    o.fullRe = {2'b00, r[NE-1:0]};
    o.rf = r[63:64-NF];
    o.cvtNegRes = {2'b00, rand64()};
    return o;
endfunction

////////////////////
// reference rules
////////////////////

// quiet nan fraction for the format
function automatic logic [NF-1:0] nanFrac(input logic dbl, input logic [NF-2:0] pay);
    logic [NF-1:0] f;
    if (dbl) begin
        f = {1'b1, pay};
    end else begin
        f = {{NF-NF1{1'b0}}, 1'b1, pay[NF-2 -: NF1-1]};
    end
    return f;
endfunction

function automatic fpWord_t refFp(input specialCaseIn_t o);
    logic           dbl;
    logic           isCvt;
    logic           isDiv;
    logic           ofSel;
    logic           kill;
    logic           toMax;
    logic           lsb;
    logic           s;
    logic [NE-1:0]  eOnes;
    logic [NE-1:0]  e;
    logic [NF-1:0]  fOnes;
    logic [NF-1:0]  f;
    fpWord_t        res;
    dbl = (o.outFmt == fmtDouble);
    isCvt = (o.op == opCvt);
    isDiv = (o.op == opDiv);
    eOnes = dbl ? {NE{1'b1}} : {{NE-NE1{1'b0}}, {NE1{1'b1}}};
    fOnes = dbl ? {NF{1'b1}} : {{NF-NF1{1'b0}}, {NF1{1'b1}}};
    ofSel = o.overflow || o.divByZero || (o.infIn && !(isDiv && o.yInf));
    if (isCvt) begin
        kill = o.cvtResUf || (o.xZero && !o.intToFp) || (o.intZero && o.intToFp);
    end else begin
        kill = o.fullRe[NE+1] || (isDiv && (o.xZero || (o.yInf && !o.xInf)));
    end
    // largest finite when rounding toward zero
    toMax = (!o.infIn || (isCvt && o.intToFp)) && !o.divByZero
          && (o.frm == rtz || (o.frm == rdn && !o.ws) || (o.frm == rup && o.ws));
    lsb = o.plus1 && o.frm[1] && !(isDiv && o.yInf);
    s = o.ws;
    if (o.xNaN && !(isCvt && o.intToFp)) begin
        s = 1'b0;
        e = eOnes;
        f = nanFrac(dbl, o.xm[NF-2:0]);
    end else if (o.yNaN && !isCvt) begin
        s = 1'b0;
        e = eOnes;
        f = nanFrac(dbl, o.ym[NF-2:0]);
    end else if (o.invalid) begin
        s = 1'b0;
        e = eOnes;
        f = nanFrac(dbl, '0);
    end else if (ofSel) begin
        e = toMax ? eOnes - 1'b1 : eOnes;
        f = toMax ? fOnes : '0;
    end else if (kill) begin
        e = '0;
        f = {{NF-1{1'b0}}, lsb};
    end else begin
        e = dbl ? o.re : {{NE-NE1{1'b0}}, o.re[NE1-1:0]};
        f = dbl ? o.rf : {{NF-NF1{1'b0}}, o.rf[NF-1 -: NF1]};
    end
    // single sits nan-boxed in the low half
    if (dbl) begin
        res = {s, e, f};
    end else begin
        res = {32'hFFFF_FFFF, s, e[NE1-1:0], f[NF1-1:0]};
    end
    return res;
endfunction

function automatic logic [XLEN-1:0] refInt(input specialCaseIn_t o);
    logic               neg;
    logic [XLEN-1:0]    res;
    // nan counts as positive
    neg = o.xs && !o.nanIn;
    if (o.intInvalid) begin
        if (o.isSigned && o.int64) begin
            res = neg ? 64'h8000_0000_0000_0000 : 64'h7FFF_FFFF_FFFF_FFFF;
        end else if (o.isSigned) begin
            res = neg ? 64'hFFFF_FFFF_8000_0000 : 64'h0000_0000_7FFF_FFFF;
        end else begin
            res = neg ? 64'h0 : 64'hFFFF_FFFF_FFFF_FFFF;
        end
    end else if (o.cvtCe[NE]) begin
        res = (neg && o.isSigned && o.plus1) ? 64'hFFFF_FFFF_FFFF_FFFF : {63'b0, o.plus1};
    end else if (o.int64) begin
        res = o.cvtNegRes[XLEN-1:0];
    end else begin
        res = {{32{o.cvtNegRes[31]}}, o.cvtNegRes[31:0]};
    end
    return res;
endfunction

////////////////////
// directed tests
////////////////////

task automatic nanPriority();
    specialCaseIn_t o;
    int             f;
    for (f = 0; f < 2; f++) begin
        // x nan beats y nan, invalid and overflow
        o = quietOp(f[0]);
        o.xNaN = 1'b1;
        o.yNaN = 1'b1;
        o.invalid = 1'b1;
        o.overflow = 1'b1;
        issueOp(o);
        // y nan beats invalid
        o = quietOp(f[0]);
        o.yNaN = 1'b1;
        o.invalid = 1'b1;
        issueOp(o);
        // canonical nan
        o = quietOp(f[0]);
        o.invalid = 1'b1;
        o.overflow = 1'b1;
        issueOp(o);
        // int-to-fp has no x operand
        o = quietOp(f[0]);
        o.op = opCvt;
        o.intToFp = 1'b1;
        o.xNaN = 1'b1;
        issueOp(o);
        // no y operand on conversions
        o = quietOp(f[0]);
        o.op = opCvt;
        o.yNaN = 1'b1;
        issueOp(o);
    end
    finishTest();
endtask

task automatic overflowCases();
    specialCaseIn_t o;
    int             f;
    int             k;
    for (f = 0; f < 2; f++) begin
        // every rounding mode with both signs
        for (k = 0; k < 10; k++) begin
            o = quietOp(f[0]);
            o.overflow = 1'b1;
            o.frm = frm_t'(k / 2);
            o.ws = k[0];
            issueOp(o);
        end
        // divide by zero is infinity even under rtz
        o = quietOp(f[0]);
        o.op = opDiv;
        o.divByZero = 1'b1;
        o.frm = rtz;
        issueOp(o);
        o = quietOp(f[0]);
        o.infIn = 1'b1;
        o.xInf = 1'b1;
        o.frm = rtz;
        issueOp(o);
        // x/inf is not an overflow
        o = quietOp(f[0]);
        o.op = opDiv;
        o.infIn = 1'b1;
        o.yInf = 1'b1;
        issueOp(o);
    end
    finishTest();
endtask

task automatic killCases();
    specialCaseIn_t o;
    int             k;
    // conversion underflow where the lsb depends on frm and plus1
    for (k = 0; k < 10; k++) begin
        o = quietOp(k[1]);
        o.op = opCvt;
        o.cvtResUf = 1'b1;
        o.frm = frm_t'(k / 2);
        o.plus1 = k[0];
        issueOp(o);
    end
    o = quietOp(1'b1);
    o.op = opCvt;
    o.xZero = 1'b1;
    o.plus1 = 1'b1;
    o.frm = rup;
    issueOp(o);
    o = quietOp(1'b0);
    o.op = opCvt;
    o.intToFp = 1'b1;
    o.intZero = 1'b1;
    o.plus1 = 1'b1;
    o.frm = rdn;
    issueOp(o);
    // zero dividend
    o = quietOp(1'b1);
    o.op = opDiv;
    o.xZero = 1'b1;
    o.plus1 = 1'b1;
    o.frm = rdn;
    issueOp(o);
    // inf divisor is exact so the lsb stays clear
    o = quietOp(1'b0);
    o.op = opDiv;
    o.yInf = 1'b1;
    o.plus1 = 1'b1;
    o.frm = rdn;
    issueOp(o);
    o = quietOp(1'b1);
    o.fullRe[NE+1] = 1'b1;
    o.plus1 = 1'b1;
    o.frm = rup;
    issueOp(o);
    finishTest();
endtask

// back to back with one issue per cycle
task automatic normalStream();
    int k;
    for (k = 0; k < 20; k++) begin
        issueOp(quietOp(k[0]));
    end
    finishTest();
endtask

task automatic intOverflowCases();
    specialCaseIn_t o;
    int             k;
    for (k = 0; k < 8; k++) begin
        o = quietOp(1'b1);
        o.op = opCvt;
        o.intInvalid = 1'b1;
        o.isSigned = k[0];
        o.int64 = k[1];
        o.xs = k[2];
        issueOp(o);
    end
    // negative nan saturates positive
    for (k = 0; k < 2; k++) begin
        o = quietOp(1'b1);
        o.op = opCvt;
        o.intInvalid = 1'b1;
        o.nanIn = 1'b1;
        o.xs = 1'b1;
        o.isSigned = 1'b1;
        o.int64 = k[0];
        issueOp(o);
    end
    finishTest();
endtask

task automatic intRangeCases();
    specialCaseIn_t o;
    int             k;
    // tiny magnitudes round to -1, 0 or 1
    for (k = 0; k < 8; k++) begin
        o = quietOp(1'b1);
        o.op = opCvt;
        o.cvtCe[NE] = 1'b1;
        o.xs = k[0];
        o.isSigned = k[1];
        o.plus1 = k[2];
        issueOp(o);
    end
    // in range where int32 sign-extends from bit 31
    for (k = 0; k < 4; k++) begin
        o = quietOp(1'b0);
        o.op = opCvt;
        o.int64 = k[1];
        o.cvtNegRes[31] = k[0];
        issueOp(o);
    end
    finishTest();
endtask

`endif

// File: dv/specialCaseTb.sv
/*
 * special case selector testbench
 */

`timescale 1ns/100ps
`default_nettype none

module specialCaseTb
    import fpFormatPkg::*;
    import specialCasePkg::*;
();

    localparam int clkPeriod = 100;
    // issues over all directed tests
    localparam int numVectors = 93;
    // four cycles per vector for issue, idle and drain plus a reset margin
    localparam int watchdogNs = numVectors * 4 * clkPeriod + 20 * clkPeriod;

    logic               clk = 1'b0;
    logic               rst;
    logic               inValid;
    specialCaseIn_t     opIn;
    logic               outValid;
    fpWord_t            fpRes;
    logic [XLEN-1:0]    intRes;

    // random stimulus seed
    integer             seed = 50;

    // results in flight with the oldest first
    int                 dueQ[$];
    fpWord_t            expFpQ[$];
    logic [XLEN-1:0]    expIntQ[$];
    // falling edges since time zero
    int                 negCount = 0;

    specialCaseTop i_specialCaseTop (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .opIn     (opIn),
        .outValid (outValid),
        .fpRes    (fpRes),
        .intRes   (intRes)
    );

    `include "specialCaseTasks.svh"

    always #(clkPeriod / 2) clk = ~clk;

    ////////////////////
    // result monitor
    ////////////////////

    // outputs are stable at the falling edge
    // an op seen here is sampled at the next rise and shows up two falls later
    always @(negedge clk) begin
        negCount = negCount + 1;
        if (!rst) begin
            if (dueQ.size() != 0 && dueQ[0] == negCount) begin
                if (outValid !== 1'b1) begin
                    $display("** Error at %0t ns: outValid missing two cycles after issue",
                             $time);
                    stopWithFailure();
                end else begin
                    checkFp("fpRes", expFpQ.pop_front(), fpRes);
                    checkInt("intRes", expIntQ.pop_front(), intRes);
                    void'(dueQ.pop_front());
                end
            end else if (outValid !== 1'b0) begin
                $display("** Error at %0t ns: outValid high with no result due", $time);
                stopWithFailure();
            end
            if (inValid) begin
                dueQ.push_back(negCount + 2);
                expFpQ.push_back(refFp(opIn));
                expIntQ.push_back(refInt(opIn));
            end
        end
    end

    // hang guard
    initial begin
        #(watchdogNs);
        $display("** Error at %0t ns: watchdog expired before the tests finished", $time);
        stopWithFailure();
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        rst = 1'b1;
        inValid = 1'b0;
        opIn = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // idle cycles while the monitor expects outValid low
        repeat (3) @(posedge clk);
        nanPriority();
        overflowCases();
        killCases();
        normalStream();
        intOverflowCases();
        intRangeCases();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: specialCaseTop.f
+incdir+dv
design/fpFormatPkg.sv
design/specialCasePkg.sv
design/resultClassifier.sv
design/fpResultFormatter.sv
design/intResultSelector.sv
design/specialCaseTop.sv
dv/specialCaseTb.sv
